//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Width of data words and of the PC
`define DATA_WIDTH 32

// Number of general purpose registers
`define REG_COUNT 32

// Fetch address after reset
`define RESET_PC 32'h0000_0000

// One instruction word per fetch
`define PC_STEP 32'd4

`endif

//--- logic/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0] reg_addr_t;

    // Low half of an R-type word
    typedef struct packed {
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // Low half read as R-type fields or as the 16-bit immediate
    typedef union packed {
        r_fields_t   r;
        logic [15:0] imm;
    } low_half_t;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        low_half_t  low;
    } instr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    ////////////////////////////////////////////////////////////////////////////
    // SPECIAL funct codes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

//--- logic/pipe_pkg.sv
`include "cpu_params.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        instr_t                 instr;
    } if_id_t;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        alu_op_e                alu_op;
        logic [`DATA_WIDTH-1:0] op_a;
        logic [`DATA_WIDTH-1:0] op_b;
        reg_addr_t              rs;
        reg_addr_t              rt;
        logic [`DATA_WIDTH-1:0] imm_ext;
        logic                   b_is_imm;
        logic [4:0]             shamt;
        logic                   shamt_from_reg;
        reg_addr_t              rd;
        logic                   reg_w;
        logic                   of_check;
    } id_ex_t;

    // reg_w here is already cleared on overflow
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        reg_addr_t              rd;
        logic [`DATA_WIDTH-1:0] result;
        logic                   reg_w;
    } ex_wb_t;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] pc;
        reg_addr_t              rd;
        logic [`DATA_WIDTH-1:0] data;
        logic                   written;
    } commit_t;

endpackage

//--- logic/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(out_valid))
        else $error("stage valid went unknown");

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hold,
    input  instr_t                 instr_data,
    output logic [`DATA_WIDTH-1:0] instr_addr,
    output if_id_t                 if_id,
    output logic                   if_id_valid
);

    logic [`DATA_WIDTH-1:0] pc;
    if_id_t                 fetched;

    // PC advances every cycle unless held
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (!hold) begin
            pc <= pc + `PC_STEP;
        end
    end

    assign instr_addr = pc;
    assign fetched    = '{pc: pc, instr: instr_data};

    stage_reg #(.payload_t(if_id_t)) i_if_id (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .hold      ( hold        ),
        .in_valid  ( 1'b1        ),
        .in_data   ( fetched     ),
        .out_valid ( if_id_valid ),
        .out_data  ( if_id       )
    );

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("PC not word aligned");

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module decode_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hold,
    input  if_id_t                 if_id,
    input  logic                   if_id_valid,
    output reg_addr_t              rs_addr,
    output reg_addr_t              rt_addr,
    input  logic [`DATA_WIDTH-1:0] rs_data,
    input  logic [`DATA_WIDTH-1:0] rt_data,
    output id_ex_t                 id_ex,
    output logic                   id_ex_valid
);

    instr_t                 instr;
    logic                   is_special;
    logic                   legal;
    logic                   of_check;
    logic                   shamt_from_reg;
    alu_op_e                alu_op;
    logic [15:0]            imm;
    logic [`DATA_WIDTH-1:0] imm_ext;
    id_ex_t                 id_next;

    assign instr      = if_id.instr;
    assign imm        = instr.low.imm;
    assign is_special = (instr.opcode == OP_SPECIAL);

    assign rs_addr = instr.rs;
    assign rt_addr = instr.rt;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode and funct decode
    ////////////////////////////////////////////////////////////////////////////

    // All-zero word is SLL into r0 and never writes
    always_comb begin
        alu_op = ALU_ADD;
        legal  = 1'b1;
        if (is_special) begin
            case (instr.low.r.funct)
                FN_ADD, FN_ADDU:  alu_op = ALU_ADD;
                FN_SUB, FN_SUBU:  alu_op = ALU_SUB;
                FN_AND:           alu_op = ALU_AND;
                FN_OR:            alu_op = ALU_OR;
                FN_XOR:           alu_op = ALU_XOR;
                FN_NOR:           alu_op = ALU_NOR;
                FN_SLT:           alu_op = ALU_SLT;
                FN_SLTU:          alu_op = ALU_SLTU;
                FN_SLL, FN_SLLV:  alu_op = ALU_SLL;
                FN_SRL, FN_SRLV:  alu_op = ALU_SRL;
                FN_SRA, FN_SRAV:  alu_op = ALU_SRA;
                default:          legal  = 1'b0;
            endcase
        end else begin
            case (instr.opcode)
                OP_ADDI, OP_ADDIU: alu_op = ALU_ADD;
                OP_SLTI:           alu_op = ALU_SLT;
                OP_SLTIU:          alu_op = ALU_SLTU;
                OP_ANDI:           alu_op = ALU_AND;
                OP_ORI:            alu_op = ALU_OR;
                OP_XORI:           alu_op = ALU_XOR;
                OP_LUI:            alu_op = ALU_LUI;
                default:           legal  = 1'b0;
            endcase
        end
    end

    assign of_check = (is_special && (instr.low.r.funct inside {FN_ADD, FN_SUB}))
                    || (instr.opcode == OP_ADDI);
    assign shamt_from_reg = is_special
                          && (instr.low.r.funct inside {FN_SLLV, FN_SRLV, FN_SRAV});

    // Logic ops zero-extend and LUI moves the immediate up
    always_comb begin
        if (instr.opcode == OP_LUI) begin
            imm_ext = {imm, {(`DATA_WIDTH-16){1'b0}}};
        end else if (instr.opcode inside {OP_ANDI, OP_ORI, OP_XORI}) begin
            imm_ext = {{(`DATA_WIDTH-16){1'b0}}, imm};
        end else begin
            imm_ext = {{(`DATA_WIDTH-16){imm[15]}}, imm};
        end
    end

    assign id_next = '{
        pc:             if_id.pc,
        alu_op:         alu_op,
        op_a:           rs_data,
        op_b:           rt_data,
        rs:             instr.rs,
        rt:             instr.rt,
        imm_ext:        imm_ext,
        b_is_imm:       !is_special,
        shamt:          instr.low.r.shamt,
        shamt_from_reg: shamt_from_reg,
        rd:             is_special ? instr.low.r.rd : instr.rt,
        reg_w:          legal,
        of_check:       of_check
    };

    stage_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .hold      ( hold        ),
        .in_valid  ( if_id_valid ),
        .in_data   ( id_next     ),
        .out_valid ( id_ex_valid ),
        .out_data  ( id_ex       )
    );

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hold,
    input  reg_addr_t              rs_addr,
    input  reg_addr_t              rt_addr,
    output logic [`DATA_WIDTH-1:0] rs_data,
    output logic [`DATA_WIDTH-1:0] rt_data,
    input  ex_wb_t                 ex_wb,
    input  logic                   ex_wb_valid,
    output commit_t                commit
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic                   wr_en;

    assign wr_en = ex_wb_valid && ex_wb.reg_w && !hold && (ex_wb.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex_wb.rd] <= ex_wb.result;
        end
    end

    // Write-through so the instruction two behind sees this cycle's result
    assign rs_data = (rs_addr == '0) ? '0
                   : (wr_en && rs_addr == ex_wb.rd) ? ex_wb.result : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0
                   : (wr_en && rt_addr == ex_wb.rd) ? ex_wb.result : regs[rt_addr];

    assign commit = '{
        valid:   ex_wb_valid && !hold,
        pc:      ex_wb.pc,
        rd:      ex_wb.rd,
        data:    ex_wb.result,
        written: wr_en
    };

    a_r0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("register zero was written");

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module execute_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   hold,
    input  id_ex_t id_ex,
    input  logic   id_ex_valid,
    output ex_wb_t ex_wb,
    output logic   ex_wb_valid
);

    localparam int MSB = `DATA_WIDTH - 1;

    logic                   wb_hit;
    logic [`DATA_WIDTH-1:0] a_fwd;
    logic [`DATA_WIDTH-1:0] b_fwd;
    logic [`DATA_WIDTH-1:0] op_b;
    logic [4:0]             shamt;
    logic [`DATA_WIDTH-1:0] result;
    logic                   b_sign;
    logic                   overflow;
    ex_wb_t                 ex_next;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding from the instruction one ahead
    ////////////////////////////////////////////////////////////////////////////

    assign wb_hit = ex_wb_valid && ex_wb.reg_w && (ex_wb.rd != '0);
    assign a_fwd  = (wb_hit && ex_wb.rd == id_ex.rs) ? ex_wb.result : id_ex.op_a;
    assign b_fwd  = (wb_hit && ex_wb.rd == id_ex.rt) ? ex_wb.result : id_ex.op_b;

    assign op_b  = id_ex.b_is_imm ? id_ex.imm_ext : b_fwd;
    assign shamt = id_ex.shamt_from_reg ? a_fwd[4:0] : id_ex.shamt;

    // ALU and a barrel shifter that shifts operand B
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  result = a_fwd + op_b;
            ALU_SUB:  result = a_fwd - op_b;
            ALU_AND:  result = a_fwd & op_b;
            ALU_OR:   result = a_fwd | op_b;
            ALU_XOR:  result = a_fwd ^ op_b;
            ALU_NOR:  result = ~(a_fwd | op_b);
            ALU_SLT:  result = {{MSB{1'b0}}, $signed(a_fwd) < $signed(op_b)};
            ALU_SLTU: result = {{MSB{1'b0}}, a_fwd < op_b};
            ALU_LUI:  result = op_b;
            ALU_SLL:  result = op_b << shamt;
            ALU_SRL:  result = op_b >> shamt;
            ALU_SRA:  result = $signed(op_b) >>> shamt;
            default:  result = '0;
        endcase
    end

    // Subtract looks like adding -B, so compare against the flipped sign
    assign b_sign   = (id_ex.alu_op == ALU_SUB) ? ~op_b[MSB] : op_b[MSB];
    assign overflow = (a_fwd[MSB] == b_sign) && (result[MSB] != a_fwd[MSB]);

    assign ex_next = '{
        pc:     id_ex.pc,
        rd:     id_ex.rd,
        result: result,
        reg_w:  id_ex.reg_w && !(id_ex.of_check && overflow)
    };

    stage_reg #(.payload_t(ex_wb_t)) i_ex_wb (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .hold      ( hold        ),
        .in_valid  ( id_ex_valid ),
        .in_data   ( ex_next     ),
        .out_valid ( ex_wb_valid ),
        .out_data  ( ex_wb       )
    );

endmodule

//--- logic/pipeline.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module pipeline
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hold,
    output logic [`DATA_WIDTH-1:0] instr_addr,
    input  instr_t                 instr_data,
    output commit_t                commit
);

    if_id_t                 if_id;
    logic                   if_id_valid;
    id_ex_t                 id_ex;
    logic                   id_ex_valid;
    ex_wb_t                 ex_wb;
    logic                   ex_wb_valid;
    reg_addr_t              rs_addr;
    reg_addr_t              rt_addr;
    logic [`DATA_WIDTH-1:0] rs_data;
    logic [`DATA_WIDTH-1:0] rt_data;

    ////////////////////////////////////////////////////////////////////////////
    // IF
    ////////////////////////////////////////////////////////////////////////////

    fetch_unit i_fetch (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .hold        ( hold        ),
        .instr_data  ( instr_data  ),
        .instr_addr  ( instr_addr  ),
        .if_id       ( if_id       ),
        .if_id_valid ( if_id_valid )
    );

    ////////////////////////////////////////////////////////////////////////////
    // ID and EX
    ////////////////////////////////////////////////////////////////////////////

    decode_unit i_decode (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .hold        ( hold        ),
        .if_id       ( if_id       ),
        .if_id_valid ( if_id_valid ),
        .rs_addr     ( rs_addr     ),
        .rt_addr     ( rt_addr     ),
        .rs_data     ( rs_data     ),
        .rt_data     ( rt_data     ),
        .id_ex       ( id_ex       ),
        .id_ex_valid ( id_ex_valid )
    );

    execute_unit i_execute (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .hold        ( hold        ),
        .id_ex       ( id_ex       ),
        .id_ex_valid ( id_ex_valid ),
        .ex_wb       ( ex_wb       ),
        .ex_wb_valid ( ex_wb_valid )
    );

    ////////////////////////////////////////////////////////////////////////////
    // WB and commit
    ////////////////////////////////////////////////////////////////////////////

    register_file i_regfile (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .hold        ( hold        ),
        .rs_addr     ( rs_addr     ),
        .rt_addr     ( rt_addr     ),
        .rs_data     ( rs_data     ),
        .rt_data     ( rt_data     ),
        .ex_wb       ( ex_wb       ),
        .ex_wb_valid ( ex_wb_valid ),
        .commit      ( commit      )
    );

endmodule

//--- testbench/tb_pipeline.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_pipeline
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_COMMITS    = 300;
    localparam int IMEM_WORDS     = 256;
    localparam int PIPE_DEPTH     = 3;
    localparam int HOLD_STRETCHES = 5;
    localparam int TIMEOUT        = NUM_COMMITS * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;

    // What one committed instruction should look like
    typedef struct packed {
        reg_addr_t              rd;
        logic [`DATA_WIDTH-1:0] data;
        logic                   written;
    } expect_t;

    logic                   clk;
    logic                   reset;
    logic                   hold;
    logic [`DATA_WIDTH-1:0] instr_addr;
    instr_t                 instr_data;
    commit_t                commit;

    logic [31:0]            imem [IMEM_WORDS];
    logic [15:0]            lfsr_state;
    logic [`DATA_WIDTH-1:0] shadow_regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] exp_pc;
    instr_t                 exp_instr;
    logic [`DATA_WIDTH-1:0] exp_a;
    logic [`DATA_WIDTH-1:0] exp_b;
    expect_t                expected;
    int                     commit_count;
    int unsigned            cycle_count = 0;
    int                     since_reset = 0;

    pipeline i_dut (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .hold       ( hold       ),
        .instr_addr ( instr_addr ),
        .instr_data ( instr_data ),
        .commit     ( commit     )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Word index wraps over 256 entries, so the program repeats
    assign instr_data = $isunknown(instr_addr) ? '0 : imem[instr_addr[9:2]];

    ////////////////////////////////////////////////////////////////////////////
    // Program generator
    ////////////////////////////////////////////////////////////////////////////

    // Taps 16, 14, 13 and 11 give a maximal length sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        repeat (count) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] r_word(input logic [5:0] funct, input reg_addr_t rs,
                                           input reg_addr_t rt, input reg_addr_t rd,
                                           input logic [4:0] shamt);
        return {OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] opcode, input reg_addr_t rs,
                                           input reg_addr_t rt, input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    task automatic make_instr(output logic [31:0] word);
        logic [31:0] raw;
        int          pick;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  shamt;
        logic [15:0] imm;
        draw_bits(5, raw);
        pick = int'(raw);
        // Leftover codes weight the overflow-prone instructions
        if (pick >= 25) begin
            pick = pick - 25;
        end
        draw_bits(3, raw);
        rs = raw[4:0];
        draw_bits(3, raw);
        rt = raw[4:0];
        draw_bits(3, raw);
        rd = raw[4:0];
        draw_bits(5, raw);
        shamt = raw[4:0];
        draw_bits(16, raw);
        imm = raw[15:0];
        draw_bits(2, raw);
        // Signed extremes make ADD, SUB and ADDI overflow now and then
        if (raw[1:0] == 2'd0) begin
            imm = 16'h7fff;
        end else if (raw[1:0] == 2'd1) begin
            imm = 16'h8000;
        end
        case (pick)
            0:       word = r_word(FN_ADD, rs, rt, rd, 5'd0);
            1:       word = r_word(FN_SUB, rs, rt, rd, 5'd0);
            2:       word = i_word(OP_ADDI, rs, rt, imm);
            3:       word = i_word(OP_LUI, 5'd0, rt, imm);
            4:       word = r_word(FN_ADDU, rs, rt, rd, 5'd0);
            5:       word = r_word(FN_SUBU, rs, rt, rd, 5'd0);
            6:       word = i_word(OP_ADDIU, rs, rt, imm);
            7:       word = r_word(FN_AND, rs, rt, rd, 5'd0);
            8:       word = r_word(FN_OR, rs, rt, rd, 5'd0);
            9:       word = r_word(FN_XOR, rs, rt, rd, 5'd0);
            10:      word = r_word(FN_NOR, rs, rt, rd, 5'd0);
            11:      word = r_word(FN_SLT, rs, rt, rd, 5'd0);
            12:      word = r_word(FN_SLTU, rs, rt, rd, 5'd0);
            13:      word = r_word(FN_SLL, 5'd0, rt, rd, shamt);
            14:      word = r_word(FN_SRL, 5'd0, rt, rd, shamt);
            15:      word = r_word(FN_SRA, 5'd0, rt, rd, shamt);
            16:      word = r_word(FN_SLLV, rs, rt, rd, 5'd0);
            17:      word = r_word(FN_SRLV, rs, rt, rd, 5'd0);
            18:      word = r_word(FN_SRAV, rs, rt, rd, 5'd0);
            19:      word = i_word(OP_SLTI, rs, rt, imm);
            20:      word = i_word(OP_SLTIU, rs, rt, imm);
            21:      word = i_word(OP_ANDI, rs, rt, imm);
            22:      word = i_word(OP_ORI, rs, rt, imm);
            23:      word = i_word(OP_XORI, rs, rt, imm);
            default: word = 32'h0000_0000;
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Overflow shows as a mismatch of the two top bits of a 33-bit sum
    function automatic expect_t predict(input instr_t ins, input logic [31:0] a,
                                        input logic [31:0] b);
        expect_t     e;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [32:0] wide;
        logic        legal;
        logic        ovf;
        sext    = {{16{ins.low.imm[15]}}, ins.low.imm};
        zext    = {16'h0000, ins.low.imm};
        legal   = 1'b1;
        ovf     = 1'b0;
        e.data  = '0;
        e.rd    = (ins.opcode == OP_SPECIAL) ? ins.low.r.rd : ins.rt;
        if (ins.opcode == OP_SPECIAL) begin
            case (ins.low.r.funct)
                FN_ADD, FN_ADDU: begin
                    wide   = {a[31], a} + {b[31], b};
                    e.data = wide[31:0];
                    ovf    = (ins.low.r.funct == FN_ADD) && (wide[32] != wide[31]);
                end
                FN_SUB, FN_SUBU: begin
                    wide   = {a[31], a} - {b[31], b};
                    e.data = wide[31:0];
                    ovf    = (ins.low.r.funct == FN_SUB) && (wide[32] != wide[31]);
                end
                FN_AND:  e.data = a & b;
                FN_OR:   e.data = a | b;
                FN_XOR:  e.data = a ^ b;
                FN_NOR:  e.data = ~(a | b);
                FN_SLT:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLTU: e.data = (a < b) ? 32'd1 : 32'd0;
                FN_SLL:  e.data = b << ins.low.r.shamt;
                FN_SRL:  e.data = b >> ins.low.r.shamt;
                FN_SRA:  e.data = $signed(b) >>> ins.low.r.shamt;
                FN_SLLV: e.data = b << a[4:0];
                FN_SRLV: e.data = b >> a[4:0];
                FN_SRAV: e.data = $signed(b) >>> a[4:0];
                default: legal  = 1'b0;
            endcase
        end else begin
            case (ins.opcode)
                OP_ADDI, OP_ADDIU: begin
                    wide   = {a[31], a} + {sext[31], sext};
                    e.data = wide[31:0];
                    ovf    = (ins.opcode == OP_ADDI) && (wide[32] != wide[31]);
                end
                OP_SLTI:  e.data = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
                OP_SLTIU: e.data = (a < sext) ? 32'd1 : 32'd0;
                OP_ANDI:  e.data = a & zext;
                OP_ORI:   e.data = a | zext;
                OP_XORI:  e.data = a ^ zext;
                OP_LUI:   e.data = {ins.low.imm, 16'h0000};
                default:  legal  = 1'b0;
            endcase
        end
        e.written = legal && !ovf && (e.rd != 5'd0);
        return e;
    endfunction

    // Next instruction in program order against the shadow registers
    assign exp_instr = imem[exp_pc[9:2]];
    assign exp_a     = shadow_regs[exp_instr.rs];
    assign exp_b     = shadow_regs[exp_instr.rt];
    assign expected  = predict(exp_instr, exp_a, exp_b);

    always @(posedge clk) begin
        if (reset) begin
            exp_pc       <= `RESET_PC;
            commit_count <= 0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                shadow_regs[i] <= '0;
            end
        end else if (commit.valid) begin
            if (expected.written) begin
                shadow_regs[expected.rd] <= expected.data;
            end
            exp_pc       <= exp_pc + `PC_STEP;
            commit_count <= commit_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (reset) begin
            since_reset <= 0;
        end else if (since_reset < 100) begin
            since_reset <= since_reset + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic flag_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "stopping on the first failed check");
    endtask

    a_reset_quiet: assert property (@(posedge clk) (reset && cycle_count != 0) |-> !commit.valid)
        else flag_error("commit valid high during reset");

    a_startup_quiet: assert property (@(posedge clk) disable iff (reset)
        (since_reset < PIPE_DEPTH) |-> !commit.valid)
        else flag_error("commit valid high before the first instruction could reach it");

    a_pc_order: assert property (@(posedge clk) disable iff (reset)
        commit.valid |-> (commit.pc == exp_pc))
        else flag_error($sformatf("commit pc %h, expected %h",
                                  $sampled(commit.pc), $sampled(exp_pc)));

    a_rd: assert property (@(posedge clk) disable iff (reset)
        commit.valid |-> (commit.rd == expected.rd))
        else flag_error($sformatf("pc %h commit rd %0d, expected %0d", $sampled(commit.pc),
                                  $sampled(commit.rd), $sampled(expected.rd)));

    a_data: assert property (@(posedge clk) disable iff (reset)
        commit.valid |-> (commit.data == expected.data))
        else flag_error($sformatf("pc %h commit data %h, expected %h", $sampled(commit.pc),
                                  $sampled(commit.data), $sampled(expected.data)));

    a_written: assert property (@(posedge clk) disable iff (reset)
        commit.valid |-> (commit.written == expected.written))
        else flag_error($sformatf("pc %h commit written %b, expected %b", $sampled(commit.pc),
                                  $sampled(commit.written), $sampled(expected.written)));

    a_hold_quiet: assert property (@(posedge clk) disable iff (reset) hold |-> !commit.valid)
        else flag_error("commit valid high while hold is high");

    a_hold_addr: assert property (@(posedge clk) disable iff (reset)
        hold |=> $stable(instr_addr))
        else flag_error($sformatf("instr_addr moved to %h during hold", $sampled(instr_addr)));

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and run control
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        lfsr_state = 16'd7;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            make_instr(imem[i]);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        wait (commit_count == NUM_COMMITS);
        @(posedge clk);
        $display("No errors");
        $finish;
    end

    // A few random hold stretches once the pipeline runs
    initial begin : hold_stretches
        logic [31:0] gap;
        logic [31:0] len;
        hold = 1'b0;
        wait (reset === 1'b0);
        repeat (HOLD_STRETCHES) begin
            draw_bits(5, gap);
            draw_bits(3, len);
            repeat (gap + 4) @(posedge clk);
            #(DRIVE_DELAY);
            hold = 1'b1;
            repeat (len + 1) @(posedge clk);
            #(DRIVE_DELAY);
            hold = 1'b0;
        end
    end

    initial begin : watchdog
        #(TIMEOUT);
        $display("The run timed out with %0d of %0d instructions committed",
                 commit_count, NUM_COMMITS);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- filelist.f
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_reg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/register_file.sv
logic/execute_unit.sv
logic/pipeline.sv
testbench/tb_pipeline.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_pipeline
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= No errors
JOBS       ?= 0
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(wildcard include/*.svh logic/*.sv testbench/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BINARY)
	./$(BINARY) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
